// File: sources.f
hw/id_pkg.sv
hw/inst_decoder.sv
hw/operand_forward.sv
hw/branch_unit.sv
hw/id_stage.sv
tests/id_stage_sva.sv
tests/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps
PASS_MSG  ?= TEST RESULT: PASS

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_id_stage.sv
`default_nettype none

module tb_id_stage;

    timeunit 1ns;
    timeprecision 1ps;

    logic               clk;
    logic               rst_i;
    logic               inst_valid_i;
    id_pkg::inst_addr_t pc_i;
    id_pkg::inst_t      inst_i;
    id_pkg::word_t      reg1_data_i;
    id_pkg::word_t      reg2_data_i;
    id_pkg::fwd_t       ex_fwd_i;
    id_pkg::fwd_t       mem_fwd_i;
    logic               reg1_read_o;
    logic               reg2_read_o;
    id_pkg::reg_addr_t  reg1_addr_o;
    id_pkg::reg_addr_t  reg2_addr_o;
    logic               branch_flag_o;
    id_pkg::inst_addr_t branch_target_addr_o;
    id_pkg::id_ex_t     id_ex_o;
    logic               id_ex_valid_o;
    int                 checks = 0;
    int                 errors = 0;

    id_stage i_dut (.*);

    function automatic id_pkg::word_t rf_word(input id_pkg::reg_addr_t a);
        return {27'd0, a} * 32'h0101_0101;
    endfunction

    // register file model answers in the same cycle
    assign reg1_data_i = rf_word(reg1_addr_o);
    assign reg2_data_i = rf_word(reg2_addr_o);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic id_pkg::inst_t encode_r(input id_pkg::reg_addr_t rs, rt, rd,
                                               input logic [4:0] sa, input id_pkg::funct_t fn);
        return {id_pkg::OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic id_pkg::inst_t encode_i(input id_pkg::opcode_t op,
                                               input id_pkg::reg_addr_t rs, rt,
                                               input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_value(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED %s %s expected %h actual %h", name, field, exp, act);
            errors++;
        end
    endtask

    task automatic drive(input id_pkg::inst_t inst, input id_pkg::inst_addr_t pc,
                         input logic valid);
        @(posedge clk);
        inst_i       <= inst;
        pc_i         <= pc;
        inst_valid_i <= valid;
        @(negedge clk);    // branch outputs settled here
    endtask

    task automatic set_fwd(input id_pkg::fwd_t ex, input id_pkg::fwd_t mem);
        @(posedge clk);
        ex_fwd_i  <= ex;
        mem_fwd_i <= mem;
    endtask

    // waits for the id/ex register to show the last instruction
    task automatic collect(input string name);
        int waited;
        waited = 0;
        @(posedge clk);
        inst_valid_i <= 1'b0;
        @(negedge clk);
        while (!id_ex_valid_o && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!id_ex_valid_o) begin
            $display("%s timed out waiting for id_ex_valid_o", name);
            errors++;
        end else begin
            check_value(name, "latency", 32'd1, 32'(waited + 1));
        end
    endtask

    task automatic decode_case(input string name, input id_pkg::inst_t inst,
                               input id_pkg::alu_op_e exp_op, input id_pkg::alu_sel_e exp_sel,
                               input id_pkg::reg_addr_t exp_wd, input logic exp_wreg,
                               input id_pkg::word_t exp_reg1, input id_pkg::word_t exp_reg2,
                               input logic exp_read1, input logic exp_read2);
        drive(inst, 32'h0040_0000, 1'b1);
        check_value(name, "reg1_read", 32'(exp_read1), 32'(reg1_read_o));
        check_value(name, "reg2_read", 32'(exp_read2), 32'(reg2_read_o));
        collect(name);
        check_value(name, "aluop", 32'(exp_op), 32'(id_ex_o.aluop));
        check_value(name, "alusel", 32'(exp_sel), 32'(id_ex_o.alusel));
        check_value(name, "wd", 32'(exp_wd), 32'(id_ex_o.wd));
        check_value(name, "wreg", 32'(exp_wreg), 32'(id_ex_o.wreg));
        check_value(name, "reg1", exp_reg1, id_ex_o.reg1);
        check_value(name, "reg2", exp_reg2, id_ex_o.reg2);
    endtask

    task automatic rtype_case(input string name, input id_pkg::funct_t fn,
                              input id_pkg::alu_op_e op, input id_pkg::alu_sel_e sel);
        id_pkg::reg_addr_t rs;
        id_pkg::reg_addr_t rt;
        id_pkg::reg_addr_t rd;
        rs = 5'($urandom);
        rt = 5'($urandom);
        rd = 5'($urandom);
        decode_case(name, encode_r(rs, rt, rd, 5'd0, fn), op, sel, rd, 1'b1,
                    rf_word(rs), rf_word(rt), 1'b1, 1'b1);
    endtask

    // ext picks sign (0), zero (1) or upper half (2) extension
    task automatic itype_case(input string name, input id_pkg::opcode_t opc,
                              input id_pkg::alu_op_e op, input id_pkg::alu_sel_e sel,
                              input logic [1:0] ext);
        id_pkg::reg_addr_t rs;
        id_pkg::reg_addr_t rt;
        logic [15:0]       imm;
        id_pkg::word_t     exp_imm;
        rs  = 5'($urandom);
        rt  = 5'($urandom);
        imm = 16'($urandom);
        case (ext)
            2'd0:    exp_imm = {{16{imm[15]}}, imm};
            2'd1:    exp_imm = {16'd0, imm};
            default: exp_imm = {imm, 16'd0};
        endcase
        decode_case(name, encode_i(opc, rs, rt, imm), op, sel, rt, 1'b1,
                    rf_word(rs), exp_imm, 1'b1, 1'b0);
    endtask

    task automatic shift_case(input string name, input id_pkg::funct_t fn,
                              input id_pkg::alu_op_e op);
        id_pkg::reg_addr_t rt;
        id_pkg::reg_addr_t rd;
        logic [4:0]        sa;
        rt = 5'($urandom);
        rd = 5'($urandom);
        sa = 5'($urandom);
        decode_case(name, encode_r(5'd0, rt, rd, sa, fn), op, id_pkg::SEL_SHIFT, rd, 1'b1,
                    {27'd0, sa}, rf_word(rt), 1'b0, 1'b1);
    endtask

    task automatic reset_idle_test();
        check_value("reset", "id_ex_valid", 32'd0, 32'(id_ex_valid_o));
        check_value("reset", "wreg", 32'd0, 32'(id_ex_o.wreg));
        check_value("reset", "branch_flag", 32'd0, 32'(branch_flag_o));
        drive({id_pkg::OP_JAL, 26'h123}, 32'h100, 1'b0);
        check_value("idle", "branch_flag", 32'd0, 32'(branch_flag_o));
        @(posedge clk);
        @(negedge clk);
        check_value("idle", "id_ex_valid", 32'd0, 32'(id_ex_valid_o));
        check_value("idle", "wreg", 32'd0, 32'(id_ex_o.wreg));
    endtask

    task automatic decode_test();
        rtype_case("or", id_pkg::FN_OR, id_pkg::ALU_OR, id_pkg::SEL_LOGIC);
        rtype_case("and", id_pkg::FN_AND, id_pkg::ALU_AND, id_pkg::SEL_LOGIC);
        rtype_case("xor", id_pkg::FN_XOR, id_pkg::ALU_XOR, id_pkg::SEL_LOGIC);
        rtype_case("nor", id_pkg::FN_NOR, id_pkg::ALU_NOR, id_pkg::SEL_LOGIC);
        rtype_case("sllv", id_pkg::FN_SLLV, id_pkg::ALU_SLL, id_pkg::SEL_SHIFT);
        rtype_case("srlv", id_pkg::FN_SRLV, id_pkg::ALU_SRL, id_pkg::SEL_SHIFT);
        rtype_case("srav", id_pkg::FN_SRAV, id_pkg::ALU_SRA, id_pkg::SEL_SHIFT);
        rtype_case("add", id_pkg::FN_ADD, id_pkg::ALU_ADD, id_pkg::SEL_ARITH);
        rtype_case("addu", id_pkg::FN_ADDU, id_pkg::ALU_ADDU, id_pkg::SEL_ARITH);
        rtype_case("sub", id_pkg::FN_SUB, id_pkg::ALU_SUB, id_pkg::SEL_ARITH);
        rtype_case("subu", id_pkg::FN_SUBU, id_pkg::ALU_SUBU, id_pkg::SEL_ARITH);
        rtype_case("slt", id_pkg::FN_SLT, id_pkg::ALU_SLT, id_pkg::SEL_ARITH);
        rtype_case("sltu", id_pkg::FN_SLTU, id_pkg::ALU_SLTU, id_pkg::SEL_ARITH);
        itype_case("ori", id_pkg::OP_ORI, id_pkg::ALU_OR, id_pkg::SEL_LOGIC, 2'd1);
        itype_case("andi", id_pkg::OP_ANDI, id_pkg::ALU_AND, id_pkg::SEL_LOGIC, 2'd1);
        itype_case("xori", id_pkg::OP_XORI, id_pkg::ALU_XOR, id_pkg::SEL_LOGIC, 2'd1);
        itype_case("lui", id_pkg::OP_LUI, id_pkg::ALU_OR, id_pkg::SEL_LOGIC, 2'd2);
        itype_case("slti", id_pkg::OP_SLTI, id_pkg::ALU_SLT, id_pkg::SEL_ARITH, 2'd0);
        itype_case("sltiu", id_pkg::OP_SLTIU, id_pkg::ALU_SLTU, id_pkg::SEL_ARITH, 2'd0);
        itype_case("addi", id_pkg::OP_ADDI, id_pkg::ALU_ADDI, id_pkg::SEL_ARITH, 2'd0);
        itype_case("addiu", id_pkg::OP_ADDIU, id_pkg::ALU_ADDIU, id_pkg::SEL_ARITH, 2'd0);
        shift_case("sll", id_pkg::FN_SLL, id_pkg::ALU_SLL);
        shift_case("srl", id_pkg::FN_SRL, id_pkg::ALU_SRL);
        shift_case("sra", id_pkg::FN_SRA, id_pkg::ALU_SRA);
    endtask

    task automatic forward_case(input string name, input id_pkg::inst_t inst,
                                input id_pkg::fwd_t ex, input id_pkg::fwd_t mem,
                                input id_pkg::word_t exp_reg1);
        set_fwd(ex, mem);
        drive(inst, 32'h0040_0100, 1'b1);
        collect(name);
        check_value(name, "reg1", exp_reg1, id_ex_o.reg1);
    endtask

    task automatic forward_test();
        id_pkg::reg_addr_t a;
        id_pkg::word_t     x;
        id_pkg::word_t     y;
        id_pkg::inst_t     inst;
        a    = 5'(($urandom % 31) + 1);
        x    = $urandom;
        y    = $urandom;
        inst = encode_r(a, a ^ 5'd1, 5'd3, 5'd0, id_pkg::FN_OR);
        forward_case("fwd_ex", inst, {1'b1, a, x}, {1'b1, a, y}, x);
        forward_case("fwd_mem", inst, {1'b0, a, x}, {1'b1, a, y}, y);    // ex not writing
        forward_case("fwd_none", inst, {1'b0, a, x}, {1'b0, a, y}, rf_word(a));
    endtask

    // rs is r5 fed from ex, rt is r6 fed from mem
    task automatic branch_case(input string name, input id_pkg::opcode_t op,
                               input logic [4:0] rt_f, input id_pkg::word_t v1,
                               input id_pkg::word_t v2, input logic exp_taken);
        id_pkg::inst_addr_t pc;
        logic [15:0]        off;
        id_pkg::inst_addr_t exp_target;
        pc         = $urandom & 32'hffff_fffc;
        off        = 16'($urandom);
        exp_target = exp_taken ? pc + 32'd4 + {{14{off[15]}}, off, 2'b00} : 32'd0;
        set_fwd({1'b1, 5'd5, v1}, {1'b1, 5'd6, v2});
        drive(encode_i(op, 5'd5, rt_f, off), pc, 1'b1);
        check_value(name, "branch_flag", 32'(exp_taken), 32'(branch_flag_o));
        check_value(name, "target", exp_target, branch_target_addr_o);
        collect(name);
    endtask

    task automatic branch_test();
        branch_case("beq_eq", id_pkg::OP_BEQ, 5'd6, 32'd5, 32'd5, 1'b1);
        branch_case("beq_ne", id_pkg::OP_BEQ, 5'd6, 32'd5, 32'd6, 1'b0);
        branch_case("bne_ne", id_pkg::OP_BNE, 5'd6, 32'd5, 32'd6, 1'b1);
        branch_case("bne_eq", id_pkg::OP_BNE, 5'd6, 32'd5, 32'd5, 1'b0);
        branch_case("bgtz_pos", id_pkg::OP_BGTZ, 5'd0, 32'd1, 32'd0, 1'b1);
        branch_case("bgtz_zero", id_pkg::OP_BGTZ, 5'd0, 32'd0, 32'd0, 1'b0);
        branch_case("bgtz_neg", id_pkg::OP_BGTZ, 5'd0, 32'hffff_ffff, 32'd0, 1'b0);
        branch_case("blez_zero", id_pkg::OP_BLEZ, 5'd0, 32'd0, 32'd0, 1'b1);
        branch_case("blez_neg", id_pkg::OP_BLEZ, 5'd0, 32'hffff_ffff, 32'd0, 1'b1);
        branch_case("blez_pos", id_pkg::OP_BLEZ, 5'd0, 32'd1, 32'd0, 1'b0);
        branch_case("bgez_zero", id_pkg::OP_REGIMM, id_pkg::RT_BGEZ, 32'd0, 32'd0, 1'b1);
        branch_case("bgez_neg", id_pkg::OP_REGIMM, id_pkg::RT_BGEZ, 32'h8000_0000, 32'd0, 1'b0);
        branch_case("bltz_neg", id_pkg::OP_REGIMM, id_pkg::RT_BLTZ, 32'hffff_ffff, 32'd0, 1'b1);
        branch_case("bltz_zero", id_pkg::OP_REGIMM, id_pkg::RT_BLTZ, 32'd0, 32'd0, 1'b0);
    endtask

    task automatic jump_case(input string name, input id_pkg::inst_t inst,
                             input id_pkg::inst_addr_t pc, input id_pkg::inst_addr_t exp_target,
                             input logic exp_wreg, input id_pkg::reg_addr_t exp_wd,
                             input id_pkg::inst_addr_t exp_link);
        drive(inst, pc, 1'b1);
        check_value(name, "branch_flag", 32'd1, 32'(branch_flag_o));
        check_value(name, "target", exp_target, branch_target_addr_o);
        collect(name);
        check_value(name, "wreg", 32'(exp_wreg), 32'(id_ex_o.wreg));
        if (exp_wreg) begin
            check_value(name, "wd", 32'(exp_wd), 32'(id_ex_o.wd));
        end
        check_value(name, "link_addr", exp_link, id_ex_o.link_addr);
    endtask

    task automatic jump_test();
        id_pkg::inst_addr_t pc;
        id_pkg::inst_addr_t pc4;
        logic [25:0]        idx;
        logic [15:0]        off;
        id_pkg::reg_addr_t  rs;
        id_pkg::reg_addr_t  rd;
        pc  = $urandom & 32'hffff_fffc;
        pc4 = pc + 32'd4;
        idx = 26'($urandom);
        off = 16'($urandom);
        rs  = 5'($urandom);
        rd  = 5'($urandom);
        set_fwd('0, '0);
        jump_case("j", {id_pkg::OP_J, idx}, pc, {pc4[31:28], idx, 2'b00}, 1'b0, 5'd0, 32'd0);
        jump_case("jal", {id_pkg::OP_JAL, idx}, pc, {pc4[31:28], idx, 2'b00}, 1'b1,
                  id_pkg::LINK_REG, pc + 32'd8);
        jump_case("jr", encode_r(rs, 5'd0, 5'd0, 5'd0, id_pkg::FN_JR), pc, rf_word(rs),
                  1'b0, 5'd0, 32'd0);
        jump_case("jalr", encode_r(rs, 5'd0, rd, 5'd0, id_pkg::FN_JALR), pc, rf_word(rs),
                  1'b1, rd, pc + 32'd8);
        set_fwd({1'b1, 5'd7, 32'd0}, '0);    // zero in rs so bgezal is taken
        jump_case("bgezal", encode_i(id_pkg::OP_REGIMM, 5'd7, id_pkg::RT_BGEZAL, off), pc,
                  pc4 + {{14{off[15]}}, off, 2'b00}, 1'b1, id_pkg::LINK_REG, pc + 32'd8);
    endtask

    task automatic delay_slot_test();
        id_pkg::inst_t nop_or;
        nop_or = encode_r(5'd1, 5'd2, 5'd3, 5'd0, id_pkg::FN_OR);
        set_fwd('0, '0);
        drive({id_pkg::OP_J, 26'h40}, 32'h0000_1000, 1'b1);
        drive(nop_or, 32'h0000_1004, 1'b1);    // slot follows back to back
        collect("delay_slot");
        check_value("delay_slot", "is_in_delayslot", 32'd1, 32'(id_ex_o.is_in_delayslot));
        drive(nop_or, 32'h0000_0100, 1'b1);
        collect("after_slot");
        check_value("after_slot", "is_in_delayslot", 32'd0, 32'(id_ex_o.is_in_delayslot));
        decode_case("mult", encode_r(5'd4, 5'd5, 5'd0, 5'd0, 6'b011000), id_pkg::ALU_NOP,
                    id_pkg::SEL_NOP, 5'd0, 1'b0, 32'd0, 32'd0, 1'b0, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h6c6a));
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        pc_i         = '0;
        inst_i       = '0;
        ex_fwd_i     = '0;
        mem_fwd_i    = '0;
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        reset_idle_test();
        decode_test();
        forward_test();
        branch_test();
        jump_test();
        delay_slot_test();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/id_stage_sva.sv
`default_nettype none

module id_stage_sva (
    input logic clk,
    input logic rst_i,
    input logic inst_valid_i,
    input logic branch_flag_i,
    input logic id_ex_valid_i,
    input logic id_ex_wreg_i
);

    timeunit 1ns;
    timeprecision 1ps;

    valid_low_after_reset: assert property (@(posedge clk) rst_i |=> !id_ex_valid_i)
        else $error("id_ex_valid_o set in the cycle after reset");

    // a write enable only travels with a valid instruction
    wreg_needs_valid: assert property (@(posedge clk) id_ex_wreg_i |-> id_ex_valid_i)
        else $error("id_ex_o.wreg set while id_ex_valid_o is low");

    no_branch_when_idle: assert property (@(posedge clk) !inst_valid_i |-> !branch_flag_i)
        else $error("branch_flag_o set while inst_valid_i is low");

endmodule

bind id_stage id_stage_sva i_sva (
    .clk           (clk),
    .rst_i         (rst_i),
    .inst_valid_i  (inst_valid_i),
    .branch_flag_i (branch_flag_o),
    .id_ex_valid_i (id_ex_valid_o),
    .id_ex_wreg_i  (id_ex_o.wreg)
);

`default_nettype wire

// File: hw/id_stage.sv
`default_nettype none

module id_stage (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               inst_valid_i,
    input  id_pkg::inst_addr_t pc_i,
    input  id_pkg::inst_t      inst_i,
    input  id_pkg::word_t      reg1_data_i,
    input  id_pkg::word_t      reg2_data_i,
    input  id_pkg::fwd_t       ex_fwd_i,
    input  id_pkg::fwd_t       mem_fwd_i,
    output logic               reg1_read_o,
    output logic               reg2_read_o,
    output id_pkg::reg_addr_t  reg1_addr_o,
    output id_pkg::reg_addr_t  reg2_addr_o,
    output logic               branch_flag_o,
    output id_pkg::inst_addr_t branch_target_addr_o,
    output id_pkg::id_ex_t     id_ex_o,
    output logic               id_ex_valid_o
);

    id_pkg::dec_ctrl_t  ctrl;
    id_pkg::word_t      reg1;
    id_pkg::word_t      reg2;
    logic               br_taken;
    id_pkg::inst_addr_t link_addr;
    logic               in_delayslot;
    id_pkg::id_ex_t     id_ex_d;

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    assign reg1_read_o = ctrl.reg1_read;
    assign reg2_read_o = ctrl.reg2_read;
    assign reg1_addr_o = inst_i[25:21];    // rs
    assign reg2_addr_o = inst_i[20:16];    // rt

    operand_forward u_fwd_rs (
        .read_i    (ctrl.reg1_read),
        .addr_i    (reg1_addr_o),
        .rf_data_i (reg1_data_i),
        .imm_i     (ctrl.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg1)
    );

    operand_forward u_fwd_rt (
        .read_i    (ctrl.reg2_read),
        .addr_i    (reg2_addr_o),
        .rf_data_i (reg2_data_i),
        .imm_i     (ctrl.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg2)
    );

    branch_unit u_branch (
        .cond_i      (ctrl.br_cond),
        .link_i      (ctrl.link),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .taken_o     (br_taken),
        .target_o    (branch_target_addr_o),
        .link_addr_o (link_addr)
    );

    assign branch_flag_o = br_taken && inst_valid_i && !rst_i;

    always_comb begin
        id_ex_d.aluop           = ctrl.aluop;
        id_ex_d.alusel          = ctrl.alusel;
        id_ex_d.reg1            = reg1;
        id_ex_d.reg2            = reg2;
        id_ex_d.wd              = ctrl.wd;
        id_ex_d.wreg            = ctrl.wreg && inst_valid_i;    // bubble writes nothing
        id_ex_d.link_addr       = link_addr;
        id_ex_d.is_in_delayslot = in_delayslot;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_ex_o       <= '0;
            id_ex_valid_o <= 1'b0;
            in_delayslot  <= 1'b0;
        end else begin
            id_ex_o       <= id_ex_d;
            id_ex_valid_o <= inst_valid_i;
            if (inst_valid_i) begin
                in_delayslot <= br_taken;    // next valid inst is the slot
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`default_nettype none

module branch_unit (
    input  id_pkg::br_cond_e   cond_i,
    input  logic               link_i,
    input  id_pkg::inst_addr_t pc_i,
    input  id_pkg::inst_t      inst_i,
    input  id_pkg::word_t      reg1_i,
    input  id_pkg::word_t      reg2_i,
    output logic               taken_o,
    output id_pkg::inst_addr_t target_o,
    output id_pkg::inst_addr_t link_addr_o
);

    id_pkg::inst_addr_t pc_plus_4;
    id_pkg::inst_addr_t pc_plus_8;
    id_pkg::word_t      br_offset;
    logic               reg1_zero;
    logic               reg1_neg;

    assign pc_plus_4 = pc_i + 32'd4;
    assign pc_plus_8 = pc_i + 32'd8;    // skip the delay slot
    assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign reg1_zero = (reg1_i == 32'd0);
    assign reg1_neg  = reg1_i[31];

    always_comb begin
        case (cond_i)
            id_pkg::BR_ALWAYS_IMM26,
            id_pkg::BR_ALWAYS_REG: taken_o = 1'b1;
            id_pkg::BR_EQ:         taken_o = (reg1_i == reg2_i);
            id_pkg::BR_NE:         taken_o = (reg1_i != reg2_i);
            id_pkg::BR_GTZ:        taken_o = !reg1_neg && !reg1_zero;
            id_pkg::BR_LEZ:        taken_o = reg1_neg || reg1_zero;
            id_pkg::BR_GEZ:        taken_o = !reg1_neg;
            id_pkg::BR_LTZ:        taken_o = reg1_neg;
            default:               taken_o = 1'b0;
        endcase
    end

    always_comb begin
        if (!taken_o) begin
            target_o = '0;
        end else if (cond_i == id_pkg::BR_ALWAYS_IMM26) begin
            target_o = {pc_plus_4[31:28], inst_i[25:0], 2'b00};    // region of the slot
        end else if (cond_i == id_pkg::BR_ALWAYS_REG) begin
            target_o = reg1_i;
        end else begin
            target_o = pc_plus_4 + br_offset;
        end
    end

    assign link_addr_o = link_i ? pc_plus_8 : '0;

endmodule

`default_nettype wire

// File: hw/operand_forward.sv
`default_nettype none

module operand_forward (
    input  logic              read_i,
    input  id_pkg::reg_addr_t addr_i,
    input  id_pkg::word_t     rf_data_i,
    input  id_pkg::word_t     imm_i,
    input  id_pkg::fwd_t      ex_fwd_i,
    input  id_pkg::fwd_t      mem_fwd_i,
    output id_pkg::word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // raw hazard against a result not yet written back
    assign ex_hit  = read_i && ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
    assign mem_hit = read_i && mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

    always_comb begin
        if (ex_hit) begin
            operand_o = ex_fwd_i.wdata;    // youngest value wins
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else if (read_i) begin
            operand_o = rf_data_i;
        end else begin
            operand_o = imm_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  id_pkg::inst_t     inst_i,
    output id_pkg::dec_ctrl_t ctrl_o
);

    id_pkg::opcode_t   opcode;
    id_pkg::funct_t    funct;
    id_pkg::reg_addr_t rs;
    id_pkg::reg_addr_t rt;
    id_pkg::reg_addr_t rd;
    logic [4:0]        shamt;
    id_pkg::word_t     imm_sext;

    assign opcode   = inst_i[31:26];
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign shamt    = inst_i[10:6];
    assign funct    = inst_i[5:0];
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};

    function automatic id_pkg::dec_ctrl_t set_op(
        input id_pkg::dec_ctrl_t base,
        input id_pkg::alu_op_e   op,
        input id_pkg::alu_sel_e  sel
    );
        id_pkg::dec_ctrl_t c;
        c        = base;
        c.aluop  = op;
        c.alusel = sel;
        return c;
    endfunction

    function automatic id_pkg::dec_ctrl_t set_br(
        input id_pkg::dec_ctrl_t base,
        input id_pkg::alu_op_e   op,
        input id_pkg::br_cond_e  cond
    );
        id_pkg::dec_ctrl_t c;
        c         = base;
        c.aluop   = op;
        c.alusel  = id_pkg::SEL_JUMP_BRANCH;
        c.br_cond = cond;
        return c;
    endfunction

    // link forms write the return address
    function automatic id_pkg::dec_ctrl_t add_link(
        input id_pkg::dec_ctrl_t base,
        input id_pkg::reg_addr_t wd
    );
        id_pkg::dec_ctrl_t c;
        c      = base;
        c.wreg = 1'b1;
        c.link = 1'b1;
        c.wd   = wd;
        return c;
    endfunction

    always_comb begin
        id_pkg::dec_ctrl_t base;
        id_pkg::dec_ctrl_t rr;
        id_pkg::dec_ctrl_t ri;
        id_pkg::dec_ctrl_t ri_z;
        id_pkg::dec_ctrl_t sh;
        id_pkg::dec_ctrl_t b1;
        id_pkg::dec_ctrl_t b2;

        base         = '0;
        base.aluop   = id_pkg::ALU_NOP;
        base.alusel  = id_pkg::SEL_NOP;
        base.br_cond = id_pkg::BR_NONE;
        base.wd      = rd;
        rr           = base;
        rr.reg1_read = 1'b1;
        rr.reg2_read = 1'b1;
        rr.wreg      = 1'b1;
        ri           = base;
        ri.reg1_read = 1'b1;
        ri.wreg      = 1'b1;
        ri.wd        = rt;
        ri.imm       = imm_sext;
        ri_z         = ri;
        ri_z.imm     = {16'd0, inst_i[15:0]};
        sh           = base;
        sh.reg2_read = 1'b1;
        sh.wreg      = 1'b1;
        sh.imm       = {27'd0, shamt};    // shift amount on operand 1
        b1           = base;
        b1.reg1_read = 1'b1;
        b2           = b1;
        b2.reg2_read = 1'b1;

        ctrl_o = base;
        case (opcode)
            id_pkg::OP_SPECIAL: begin
                if (shamt == 5'd0) begin
                    case (funct)
                        id_pkg::FN_OR:   ctrl_o = set_op(rr, id_pkg::ALU_OR, id_pkg::SEL_LOGIC);
                        id_pkg::FN_AND:  ctrl_o = set_op(rr, id_pkg::ALU_AND, id_pkg::SEL_LOGIC);
                        id_pkg::FN_XOR:  ctrl_o = set_op(rr, id_pkg::ALU_XOR, id_pkg::SEL_LOGIC);
                        id_pkg::FN_NOR:  ctrl_o = set_op(rr, id_pkg::ALU_NOR, id_pkg::SEL_LOGIC);
                        id_pkg::FN_SLLV: ctrl_o = set_op(rr, id_pkg::ALU_SLL, id_pkg::SEL_SHIFT);
                        id_pkg::FN_SRLV: ctrl_o = set_op(rr, id_pkg::ALU_SRL, id_pkg::SEL_SHIFT);
                        id_pkg::FN_SRAV: ctrl_o = set_op(rr, id_pkg::ALU_SRA, id_pkg::SEL_SHIFT);
                        id_pkg::FN_SLT:  ctrl_o = set_op(rr, id_pkg::ALU_SLT, id_pkg::SEL_ARITH);
                        id_pkg::FN_SLTU: ctrl_o = set_op(rr, id_pkg::ALU_SLTU, id_pkg::SEL_ARITH);
                        id_pkg::FN_ADD:  ctrl_o = set_op(rr, id_pkg::ALU_ADD, id_pkg::SEL_ARITH);
                        id_pkg::FN_ADDU: ctrl_o = set_op(rr, id_pkg::ALU_ADDU, id_pkg::SEL_ARITH);
                        id_pkg::FN_SUB:  ctrl_o = set_op(rr, id_pkg::ALU_SUB, id_pkg::SEL_ARITH);
                        id_pkg::FN_SUBU: ctrl_o = set_op(rr, id_pkg::ALU_SUBU, id_pkg::SEL_ARITH);
                        id_pkg::FN_JR: begin
                            ctrl_o = set_br(b1, id_pkg::ALU_JR, id_pkg::BR_ALWAYS_REG);
                        end
                        id_pkg::FN_JALR: begin
                            ctrl_o = set_br(b1, id_pkg::ALU_JALR, id_pkg::BR_ALWAYS_REG);
                            ctrl_o = add_link(ctrl_o, rd);
                        end
                        default: ctrl_o = base;
                    endcase
                end
                if (rs == 5'd0) begin    // sll/srl/sra need bits 31..21 clear
                    case (funct)
                        id_pkg::FN_SLL: ctrl_o = set_op(sh, id_pkg::ALU_SLL, id_pkg::SEL_SHIFT);
                        id_pkg::FN_SRL: ctrl_o = set_op(sh, id_pkg::ALU_SRL, id_pkg::SEL_SHIFT);
                        id_pkg::FN_SRA: ctrl_o = set_op(sh, id_pkg::ALU_SRA, id_pkg::SEL_SHIFT);
                        default: begin
                        end
                    endcase
                end
            end
            id_pkg::OP_REGIMM: begin
                case (rt)
                    id_pkg::RT_BLTZ: ctrl_o = set_br(b1, id_pkg::ALU_BLTZ, id_pkg::BR_LTZ);
                    id_pkg::RT_BGEZ: ctrl_o = set_br(b1, id_pkg::ALU_BGEZ, id_pkg::BR_GEZ);
                    id_pkg::RT_BLTZAL: begin
                        ctrl_o = set_br(b1, id_pkg::ALU_BLTZAL, id_pkg::BR_LTZ);
                        ctrl_o = add_link(ctrl_o, id_pkg::LINK_REG);
                    end
                    id_pkg::RT_BGEZAL: begin
                        ctrl_o = set_br(b1, id_pkg::ALU_BGEZAL, id_pkg::BR_GEZ);
                        ctrl_o = add_link(ctrl_o, id_pkg::LINK_REG);
                    end
                    default: ctrl_o = base;
                endcase
            end
            id_pkg::OP_J:    ctrl_o = set_br(base, id_pkg::ALU_J, id_pkg::BR_ALWAYS_IMM26);
            id_pkg::OP_JAL: begin
                ctrl_o = set_br(base, id_pkg::ALU_JAL, id_pkg::BR_ALWAYS_IMM26);
                ctrl_o = add_link(ctrl_o, id_pkg::LINK_REG);
            end
            id_pkg::OP_BEQ:   ctrl_o = set_br(b2, id_pkg::ALU_BEQ, id_pkg::BR_EQ);
            id_pkg::OP_BNE:   ctrl_o = set_br(b2, id_pkg::ALU_BNE, id_pkg::BR_NE);
            id_pkg::OP_BLEZ:  ctrl_o = set_br(b1, id_pkg::ALU_BLEZ, id_pkg::BR_LEZ);
            id_pkg::OP_BGTZ:  ctrl_o = set_br(b1, id_pkg::ALU_BGTZ, id_pkg::BR_GTZ);
            id_pkg::OP_ADDI:  ctrl_o = set_op(ri, id_pkg::ALU_ADDI, id_pkg::SEL_ARITH);
            id_pkg::OP_ADDIU: ctrl_o = set_op(ri, id_pkg::ALU_ADDIU, id_pkg::SEL_ARITH);
            id_pkg::OP_SLTI:  ctrl_o = set_op(ri, id_pkg::ALU_SLT, id_pkg::SEL_ARITH);
            id_pkg::OP_SLTIU: ctrl_o = set_op(ri, id_pkg::ALU_SLTU, id_pkg::SEL_ARITH);
            id_pkg::OP_ANDI:  ctrl_o = set_op(ri_z, id_pkg::ALU_AND, id_pkg::SEL_LOGIC);
            id_pkg::OP_ORI:   ctrl_o = set_op(ri_z, id_pkg::ALU_OR, id_pkg::SEL_LOGIC);
            id_pkg::OP_XORI:  ctrl_o = set_op(ri_z, id_pkg::ALU_XOR, id_pkg::SEL_LOGIC);
            id_pkg::OP_LUI: begin
                ctrl_o     = set_op(ri, id_pkg::ALU_OR, id_pkg::SEL_LOGIC);  // or with rs=$0
                ctrl_o.imm = {inst_i[15:0], 16'd0};
            end
            default: ctrl_o = base;    // dropped ops fall to nop
        endcase
    end

endmodule

`default_nettype wire

// File: hw/id_pkg.sv
`default_nettype none

package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  rt_code_t;

    localparam reg_addr_t LINK_REG = 5'd31;    // $ra

    localparam opcode_t OP_SPECIAL = 6'b000000, OP_REGIMM = 6'b000001;
    localparam opcode_t OP_J       = 6'b000010, OP_JAL    = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100, OP_BNE    = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110, OP_BGTZ   = 6'b000111;
    localparam opcode_t OP_ADDI    = 6'b001000, OP_ADDIU  = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010, OP_SLTIU  = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100, OP_ORI    = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110, OP_LUI    = 6'b001111;

    localparam funct_t FN_SLL  = 6'b000000, FN_SRL  = 6'b000010, FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100, FN_SRLV = 6'b000110, FN_SRAV = 6'b000111;
    localparam funct_t FN_JR   = 6'b001000, FN_JALR = 6'b001001;
    localparam funct_t FN_ADD  = 6'b100000, FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010, FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100, FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110, FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010, FN_SLTU = 6'b101011;

    // rt field under REGIMM
    localparam rt_code_t RT_BLTZ   = 5'b00000, RT_BGEZ   = 5'b00001;
    localparam rt_code_t RT_BLTZAL = 5'b10000, RT_BGEZAL = 5'b10001;

    typedef enum logic [7:0] {
        ALU_NOP    = 8'h00, ALU_OR     = 8'h25, ALU_AND   = 8'h24, ALU_XOR  = 8'h26,
        ALU_NOR    = 8'h27, ALU_SLL    = 8'h7c, ALU_SRL   = 8'h02, ALU_SRA  = 8'h03,
        ALU_SLT    = 8'h2a, ALU_SLTU   = 8'h2b, ALU_ADD   = 8'h20, ALU_ADDU = 8'h21,
        ALU_ADDI   = 8'h55, ALU_ADDIU  = 8'h56, ALU_SUB   = 8'h22, ALU_SUBU = 8'h23,
        ALU_J      = 8'h4f, ALU_JAL    = 8'h50, ALU_JR    = 8'h08, ALU_JALR = 8'h09,
        ALU_BEQ    = 8'h51, ALU_BNE    = 8'h52, ALU_BGTZ  = 8'h54, ALU_BLEZ = 8'h53,
        ALU_BGEZ   = 8'h41, ALU_BGEZAL = 8'h4b, ALU_BLTZ  = 8'h40, ALU_BLTZAL = 8'h4a
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_ARITH       = 3'b100,
        SEL_JUMP_BRANCH = 3'b110
    } alu_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_ALWAYS_IMM26, BR_ALWAYS_REG,
        BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
    } br_cond_e;

    // write-back in flight from EX or MEM
    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        logic      wreg;
        reg_addr_t wd;
        logic      reg1_read;
        logic      reg2_read;
        logic      link;      // writes pc+8
        br_cond_e  br_cond;
        word_t     imm;       // already extended
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_e    aluop;
        alu_sel_e   alusel;
        word_t      reg1;
        word_t      reg2;
        reg_addr_t  wd;
        logic       wreg;
        inst_addr_t link_addr;
        logic       is_in_delayslot;
    } id_ex_t;

endpackage

`default_nettype wire
